/* compile.f */
+incdir+sim
src/esp_link_pkg.sv
src/spi_slave_link.sv
src/command_parser.sv
src/control_regs.sv
src/flash_spi_master.sv
src/esp_bridge_top.sv
sim/tb_esp_bridge.sv

/* Bender.yml */
package:
  name: esp_bridge

sources:
  - src/esp_link_pkg.sv
  - src/spi_slave_link.sv
  - src/command_parser.sv
  - src/control_regs.sv
  - src/flash_spi_master.sv
  - src/esp_bridge_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_esp_bridge.sv

/* sim/esp_bridge_tests.svh */
// inputs change 2 ns after the rising clock edge
task automatic wait_drive_slot();
  @(posedge clk);
  #2;
endtask

task automatic check_value(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
  assert (actual === expected) else begin
    $display("Error: %s expected %h actual %h", name, expected, actual);
    $display("Verification failed");
    $fatal(1, "%s mismatch", name);
  end
endtask

// one mode 0 byte with eight clocks per sck half and miso taken as sck rises
task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
  for (int i = 7; i >= 0; i--) begin
    mosi = tx[i];
    repeat (8) wait_drive_slot();
    rx[i] = miso;
    sck   = 1'b1;
    repeat (8) wait_drive_slot();
    sck = 1'b0;
  end
endtask

task automatic begin_frame();
  wait_drive_slot();
  cs = 1'b0;
endtask

task automatic end_frame();
  repeat (4) wait_drive_slot();
  cs = 1'b1;
  repeat (8) wait_drive_slot();
endtask

// reply arrives on the dummy byte after the opcode
task automatic read_reg(input opcode_t op, output logic [7:0] reply);
  logic [7:0] ignored_rx;
  begin_frame();
  spi_xfer(op, ignored_rx);
  spi_xfer(8'h00, reply);
  end_frame();
endtask

task automatic write_reg(input opcode_t op, input logic [7:0] param);
  logic [7:0] ignored_rx;
  begin_frame();
  spi_xfer(op, ignored_rx);
  spi_xfer(param, ignored_rx);
  end_frame();
endtask

task automatic test_reset_state();
  check_value("reset rgb", 8'h00, {led_blue, led_green, led_red});
  check_value("reset led", 8'h00, led);
  check_value("reset esp_status", 8'h00, esp_status);
  check_value("reset flash cs_n", 8'h01, flash_spi_cs_n);
  check_value("reset flash clk", 8'h00, flash_spi_clk);
endtask

task automatic test_reads();
  logic [7:0] reply;
  read_reg(op_get_cookie, reply);
  check_value("get_cookie", 8'haf, reply);
  read_reg(op_get_version, reply);
  check_value("get_version", 8'h03, reply);
  // switches are active low, so the reply is the inverse
  read_reg(op_get_config, reply);
  check_value("get_config", {4'h0, ~conf}, reply);
endtask

task automatic test_writes();
  logic [7:0] led_param;
  logic [7:0] status;
  led_param = 8'($random(seed));
  write_reg(op_set_led, led_param);
  check_value("set_led", {5'd0, led_param[2:0]}, {led_blue, led_green, led_red});
  status = 8'($random(seed));
  write_reg(op_set_esp_status, status);
  check_value("set_esp_status", status, esp_status);
endtask

task automatic test_flash_exchange();
  logic [7:0] out_byte;
  logic [7:0] model_byte;
  logic [7:0] reply;
  int         low_clks;
  write_reg(op_set_spi_ctrl, 8'h80);
  check_value("flash select", 8'h00, flash_spi_cs_n);
  out_byte   = 8'($random(seed));
  model_byte = 8'($random(seed));
  flash_tx_q = model_byte;
  write_reg(op_set_spi_data, out_byte);
  // transfer is over once sck has idled for a long stretch
  low_clks = 0;
  while (low_clks < 200) begin
    wait_drive_slot();
    if (flash_spi_clk)
      low_clks = 0;
    else
      low_clks++;
  end
  check_value("flash si capture", out_byte, flash_si_q);
  read_reg(op_get_spi_data, reply);
  check_value("get_spi_data", model_byte, reply);
  write_reg(op_set_spi_ctrl, 8'h00);
  check_value("flash deselect", 8'h01, flash_spi_cs_n);
endtask

task automatic test_error_flag();
  logic [7:0] ignored_rx;
  logic [7:0] rnd;
  logic [7:0] led_param;
  begin_frame();
  spi_xfer(8'd3, ignored_rx);
  end_frame();
  check_value("unknown opcode", 8'h08, led);
  // new rgb value differs from the current one in every bit
  rnd       = 8'($random(seed));
  led_param = {rnd[7:3], ~{led_blue, led_green, led_red}};
  write_reg(op_set_led, led_param);
  check_value("error flag sticky", 8'h08, led);
  check_value("set_led after error", {5'd0, led_param[2:0]}, {led_blue, led_green, led_red});
endtask

/* sim/tb_esp_bridge.sv */
`timescale 1ns/1ns

module tb_esp_bridge;
  import esp_link_pkg::*;

  // about 21 spi bytes at 640 ns per bit, plus one flash byte and its idle wait
  localparam int traffic_ns  = 21 * 8 * 640;
  localparam int flash_ns    = (128 + 200) * 40;
  // margin covers frame gaps and reset
  localparam int watchdog_ns = (traffic_ns + flash_ns) * 5 / 3;

  logic       clk;
  logic       cass_out_sel_n;
  logic       sck;
  logic       cs;
  logic       mosi;
  wire        miso;
  logic [3:0] conf;
  logic       led_red;
  logic       led_green;
  logic       led_blue;
  logic [3:0] led;
  logic [7:0] esp_status;
  logic       flash_spi_cs_n;
  logic       flash_spi_clk;
  logic       flash_spi_si;
  logic       flash_spi_so;
  logic [7:0] flash_tx_q;
  logic [7:0] flash_si_q;
  int         seed;

  esp_bridge_top dut (.*);

  `include "esp_bridge_tests.svh"

  always #20 clk = ~clk;

  // flash device model shifts so out on falling sck and takes si on rising sck
  assign flash_spi_so = flash_tx_q[7];

  always @(negedge flash_spi_clk) begin
    if (flash_spi_cs_n === 1'b0)
      flash_tx_q <= {flash_tx_q[6:0], 1'b0};
  end

  always @(posedge flash_spi_clk) begin
    if (flash_spi_cs_n === 1'b0)
      flash_si_q <= {flash_si_q[6:0], flash_spi_si};
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("watchdog expired after %0d ns before the tests completed", watchdog_ns);
    $display("Verification failed");
    $fatal(1, "timeout");
  end

  initial begin
    seed           = 83653;
    clk            = 1'b0;
    cass_out_sel_n = 1'b0;
    sck            = 1'b0;
    cs             = 1'b1;
    mosi           = 1'b0;
    conf           = 4'($random(seed));
    flash_tx_q     = 8'h00;
    flash_si_q     = 8'h00;
    repeat (8) @(posedge clk);
    #2;
    cass_out_sel_n = 1'b1;
    wait_drive_slot();

    test_reset_state();
    test_reads();
    test_writes();
    test_flash_exchange();
    test_error_flag();

    $display("Verification passed");
    $finish;
  end

endmodule

/* src/esp_bridge_top.sv */
`timescale 1ns/1ns

module esp_bridge_top (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       sck,
  input  logic       cs,
  input  logic       mosi,
  output tri logic   miso,
  input  logic [3:0] conf,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic [3:0] led,
  output logic [7:0] esp_status,
  output logic       flash_spi_cs_n,
  output logic       flash_spi_clk,
  output logic       flash_spi_si,
  input  logic       flash_spi_so
);
  import esp_link_pkg::*;

  logic [7:0] rx_byte;
  logic       rx_valid;
  cmd_event_t cmd;
  logic       bad_opcode;
  led_rgb_t   led_word;
  logic       flash_cs;
  logic       spi_error;
  logic [7:0] reply_byte;
  logic [7:0] flash_rx;

  spi_slave_link u_spi_slave_link (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs             (cs),
    .mosi           (mosi),
    .miso           (miso),
    .reply_byte     (reply_byte),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid)
  );

  command_parser u_command_parser (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .cmd            (cmd),
    .bad_opcode     (bad_opcode)
  );

  control_regs u_control_regs (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd),
    .bad_opcode     (bad_opcode),
    .conf           (conf),
    .flash_rx       (flash_rx),
    .led            (led_word),
    .esp_status     (esp_status),
    .flash_cs       (flash_cs),
    .spi_error      (spi_error),
    .reply_byte     (reply_byte)
  );

  // busy is only watched inside the master
  flash_spi_master u_flash_spi_master (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd),
    .flash_cs       (flash_cs),
    .flash_rx       (flash_rx),
    .busy           (),
    .flash_spi_cs_n (flash_spi_cs_n),
    .flash_spi_clk  (flash_spi_clk),
    .flash_spi_si   (flash_spi_si),
    .flash_spi_so   (flash_spi_so)
  );

  assign led_red   = led_word.red;
  assign led_green = led_word.green;
  assign led_blue  = led_word.blue;

  // protocol error on the top board led
  assign led = {spi_error, 3'b000};

endmodule

/* src/flash_spi_master.sv */
`timescale 1ns/1ns

module flash_spi_master (
  input  logic                     clk,
  input  logic                     cass_out_sel_n,
  input  esp_link_pkg::cmd_event_t cmd,
  input  logic                     flash_cs,
  output logic [7:0]               flash_rx,
  output logic                     busy,
  output logic                     flash_spi_cs_n,
  output logic                     flash_spi_clk,
  output logic                     flash_spi_si,
  input  logic                     flash_spi_so
);
  import esp_link_pkg::*;

  logic [flash_cnt_w-1:0]   cnt;
  logic [flash_phase_w-1:0] phase;
  logic [7:0]               shift_q;
  logic                     start;

  assign phase = cnt[flash_phase_w-1:0];
  assign busy  = cnt[flash_cnt_w-1];

  // new data while a byte is still going out is dropped
  assign start = cmd.valid && (cmd.opcode == op_set_spi_data) && !busy;

  // counter runs from top bit set until it wraps to zero
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      cnt          <= '0;
      flash_spi_si <= 1'b0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      // start of low half
      if (phase == '0)
        flash_spi_si <= shift_q[7];
    end else if (start) begin
      cnt                <= '0;
      cnt[flash_cnt_w-1] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      if (phase == flash_sample_phase)
        shift_q <= {shift_q[6:0], flash_spi_so};
    end else if (start) begin
      shift_q <= cmd.param;
    end
  end

  assign flash_rx       = shift_q;
  assign flash_spi_clk  = cnt[flash_phase_w-1];
  assign flash_spi_cs_n = ~flash_cs;

  // idle clock level is low between transfers
  assert property (@(posedge clk) disable iff (!cass_out_sel_n) !busy |-> !flash_spi_clk);

endmodule

/* src/control_regs.sv */
`timescale 1ns/1ns

module control_regs (
  input  logic                     clk,
  input  logic                     cass_out_sel_n,
  input  esp_link_pkg::cmd_event_t cmd,
  input  logic                     bad_opcode,
  input  logic [3:0]               conf,
  input  logic [7:0]               flash_rx,
  output esp_link_pkg::led_rgb_t   led,
  output logic [7:0]               esp_status,
  output logic                     flash_cs,
  output logic                     spi_error,
  output logic [7:0]               reply_byte
);
  import esp_link_pkg::*;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led        <= '0;
      esp_status <= '0;
      flash_cs   <= 1'b0;
      spi_error  <= 1'b0;
      reply_byte <= '0;
    end else begin
      // sticky until the next reset
      if (bad_opcode)
        spi_error <= 1'b1;

      if (cmd.valid) begin
        case (cmd.opcode)
          op_set_led: begin
            led <= led_rgb_t'(cmd.param[2:0]);
          end
          op_set_esp_status: begin
            esp_status <= cmd.param;
          end
          op_set_spi_ctrl: begin
            // only bit 7, the flash chip select, is kept
            flash_cs <= cmd.param[7];
          end
          op_get_cookie: begin
            reply_byte <= cookie;
          end
          op_get_version: begin
            reply_byte <= {version_major, version_minor};
          end
          op_get_config: begin
            // switches read low when on
            reply_byte <= {4'b0000, ~conf};
          end
          op_get_spi_data: begin
            reply_byte <= flash_rx;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

/* src/command_parser.sv */
`timescale 1ns/1ns

module command_parser (
  input  logic                     clk,
  input  logic                     cass_out_sel_n,
  input  logic [7:0]               rx_byte,
  input  logic                     rx_valid,
  output esp_link_pkg::cmd_event_t cmd,
  output logic                     bad_opcode
);
  import esp_link_pkg::*;

  typedef enum logic {
    idle,
    read_params
  } state_t;

  state_t     state;
  opcode_t    opcode_q;
  logic [7:0] param_q [max_params];
  param_cnt_t param_cnt;
  param_cnt_t param_idx;
  param_cnt_t op_params;
  logic       op_known;
  logic       valid_q;
  logic       bad_q;

  // parameter bytes per opcode
  always_comb begin
    op_known  = 1'b1;
    op_params = '0;
    case (rx_byte)
      op_get_cookie,
      op_get_version,
      op_get_config,
      op_get_spi_data: begin
        op_params = '0;
      end
      op_set_led,
      op_set_spi_ctrl,
      op_set_spi_data,
      op_set_esp_status: begin
        op_params = param_cnt_t'(1);
      end
      default: begin
        op_known = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state     <= idle;
      param_cnt <= '0;
      param_idx <= '0;
      valid_q   <= 1'b0;
      bad_q     <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      bad_q   <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            param_idx <= '0;
            if (!op_known) begin
              bad_q <= 1'b1;
            end else if (op_params == '0) begin
              valid_q <= 1'b1;
            end else begin
              param_cnt <= op_params;
              state     <= read_params;
            end
          end
          read_params: begin
            param_idx <= param_idx + param_cnt_t'(1);
            if (param_cnt == param_cnt_t'(1)) begin
              valid_q <= 1'b1;
              state   <= idle;
            end
            param_cnt <= param_cnt - param_cnt_t'(1);
          end
          default: begin
            state <= idle;
          end
        endcase
      end
    end
  end

  // opcode and parameter store
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      if (state == idle)
        opcode_q <= rx_byte;
      else
        param_q[param_idx] <= rx_byte;
    end
  end

  assign cmd.valid  = valid_q;
  assign cmd.opcode = opcode_q;
  assign cmd.param  = param_q[0];
  assign bad_opcode = bad_q;

  assert property (@(posedge clk) disable iff (!cass_out_sel_n) !(cmd.valid && bad_opcode));

  assert property (@(posedge clk) disable iff (!cass_out_sel_n) param_cnt <= max_params);

endmodule

/* src/spi_slave_link.sv */
`timescale 1ns/1ns

module spi_slave_link (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       sck,
  input  logic       cs,
  input  logic       mosi,
  output tri logic   miso,
  input  logic [7:0] reply_byte,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] mosi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  // three stages on sck and cs, two on mosi
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_q  <= '0;
      cs_q   <= '1;
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);
  assign cs_active = ~cs_q[2];

  // bit counter with a byte strobe after the eighth rising edge
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7)
          rx_valid <= 1'b1;
      end
    end
  end

  // mode 0 samples mosi on rise and moves miso on fall
  always_ff @(posedge clk) begin
    if (cs_active) begin
      if (sck_rise)
        rx_shift <= {rx_shift[6:0], mosi_q[1]};
      if (sck_fall) begin
        // falling edge that closes a byte puts the next reply msb out
        if (bit_cnt == 3'd0)
          tx_shift <= reply_byte;
        else
          tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

  assign rx_byte = rx_shift;
  assign miso    = cs_active ? tx_shift[7] : 1'bz;

  // bytes are at least eight sck edges apart
  assert property (@(posedge clk) disable iff (!cass_out_sel_n) rx_valid |=> !rx_valid);

endmodule

/* src/esp_link_pkg.sv */
package esp_link_pkg;

  // opcode word as received from the esp
  typedef logic [7:0] opcode_t;

  // reads answered on the following byte
  localparam opcode_t op_get_cookie     = 8'd0;
  localparam opcode_t op_get_version    = 8'd15;
  localparam opcode_t op_get_config     = 8'd27;
  localparam opcode_t op_get_spi_data   = 8'd31;

  // writes with one parameter byte each
  localparam opcode_t op_set_led        = 8'd26;
  localparam opcode_t op_set_spi_ctrl   = 8'd29;
  localparam opcode_t op_set_spi_data   = 8'd30;
  localparam opcode_t op_set_esp_status = 8'd32;

  // identification bytes
  localparam logic [7:0] cookie        = 8'haf;
  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;

  // size of the parser's parameter store
  localparam int max_params = 1;

  // clocks per flash sck period
  localparam int flash_bit_period = 16;

  // phase bits cover one sck period, three more count the bits, top bit is busy
  localparam int flash_phase_w = $clog2(flash_bit_period);
  localparam int flash_cnt_w   = flash_phase_w + 4;

  // so is sampled half way through the high half
  localparam logic [flash_phase_w-1:0] flash_sample_phase =
    flash_phase_w'(flash_bit_period * 3 / 4);

  // remaining parameter bytes of the command in progress
  typedef logic [$clog2(max_params + 1)-1:0] param_cnt_t;

  // one completed command from the parser
  typedef struct packed {
    logic       valid;
    opcode_t    opcode;
    logic [7:0] param;
  } cmd_event_t;

  // rgb status led; red sits in bit 0 to match the set_led parameter
  typedef struct packed {
    logic blue;
    logic green;
    logic red;
  } led_rgb_t;

endpackage
